// File: design/cpuPkg.sv
// Execute pipe shared definitions

package cpuPkg;

  ////////////////////
  // Widths and sizes
  ////////////////////
  localparam int DataW    = 16;              // Register and data path width
  localparam int RegIdW   = 4;               // Register ID width
  localparam int NumRegs  = 16;              // Entries in the register file
  localparam int MemAddrW = 4;               // Data memory address taken from operand A low bits
  localparam int MemWords = 1 << MemAddrW;   // Words of data memory
  localparam int ImmW     = 8;               // Immediate field width for LLI
  localparam int ShamtW   = $clog2(DataW);   // Shift amount bits taken from operand B

  ////////////////////
  // Opcodes
  ////////////////////
  // Every opcode except OP_SW writes a register at write-back
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,  // A + B
    OP_SUB = 3'd1,  // A - B
    OP_AND = 3'd2,  // A & B
    OP_XOR = 3'd3,  // A ^ B
    OP_SLL = 3'd4,  // A shifted left by the low bits of B
    OP_LLI = 3'd5,  // Zero extended immediate
    OP_LW  = 3'd6,  // Load from data memory at address A
    OP_SW  = 3'd7   // Store B to data memory at address A
  } aluOpE;

  ////////////////////
  // Forward selects
  ////////////////////
  // The encoding 11 is never produced
  typedef enum logic [1:0] {
    FWD_NONE  = 2'b00,  // Use the register file read
    FWD_MEMWB = 2'b01,  // Use the value sitting in MEM/WB
    FWD_EXMEM = 2'b10   // Use the ALU result sitting in EX/MEM
  } fwdSelE;

endpackage

// File: design/OperandFetch.sv
// Operand fetch stage
`timescale 1ns/100ps

module OperandFetch import cpuPkg::*; (
  input  logic              clk,
  input  logic              rstN,
  // Issue side
  input  logic              issueValid,
  input  aluOpE             issueOp,
  input  logic [RegIdW-1:0] issueSrc1,
  input  logic [RegIdW-1:0] issueSrc2,
  input  logic [RegIdW-1:0] issueDst,
  input  logic [ImmW-1:0]   issueImm,
  // Write-back side from MEM/WB
  input  logic              wbValid,
  input  logic              wbWrite,
  input  logic [RegIdW-1:0] wbReg,
  input  logic [DataW-1:0]  wbData,
  // ID/EX pipeline register
  output logic              idExValid,
  output aluOpE             idExOp,
  output logic [RegIdW-1:0] idExSrc1,
  output logic [RegIdW-1:0] idExSrc2,
  output logic [RegIdW-1:0] idExDst,
  output logic              idExRegWrite,
  output logic [ImmW-1:0]   idExImm,
  output logic [DataW-1:0]  idExData1,
  output logic [DataW-1:0]  idExData2
);

  logic [DataW-1:0] regFile [NumRegs];  // Sixteen architectural registers
  logic             rfWrite;            // A write-back commits to the register file this cycle
  logic             issueRegWrite;      // Write enable derived from the issued opcode
  logic [DataW-1:0] readData1;          // Source 1 after the write-through check
  logic [DataW-1:0] readData2;          // Source 2 after the write-through check

  ////////////////////
  // Register file
  ////////////////////
  // Register 0 is never written so it keeps its reset value of zero
  assign rfWrite = wbValid & wbWrite & (wbReg != '0);

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < NumRegs; i++) begin
        regFile[i] <= '0;
      end
    end else if (rfWrite) begin
      regFile[wbReg] <= wbData;  // Write-back lands at the end of the WB cycle
    end
  end

  // The register being written this cycle is passed straight through
  // so a reader issued in the same cycle sees the new value
  always_comb begin
    readData1 = regFile[issueSrc1];
    readData2 = regFile[issueSrc2];
    if (rfWrite && (wbReg == issueSrc1)) begin
      readData1 = wbData;
    end
    if (rfWrite && (wbReg == issueSrc2)) begin
      readData2 = wbData;
    end
  end

  // Stores are the only opcode without a register result
  assign issueRegWrite = issueValid & (issueOp != OP_SW);

  ////////////////////
  // ID/EX register
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      idExValid    <= 1'b0;
      idExRegWrite <= 1'b0;
      idExOp       <= OP_ADD;
      idExSrc1     <= '0;
      idExSrc2     <= '0;
      idExDst      <= '0;
    end else begin
      idExValid    <= issueValid;     // A bubble leaves this low
      idExRegWrite <= issueRegWrite;  // Already cleared for a bubble
      idExOp       <= issueOp;
      idExSrc1     <= issueSrc1;
      idExSrc2     <= issueSrc2;
      idExDst      <= issueDst;
    end
  end

  // Operand payload follows the control fields without a reset
  always_ff @(posedge clk) begin
    idExImm   <= issueImm;
    idExData1 <= readData1;
    idExData2 <= readData2;
  end

endmodule

// File: design/ForwardingUnit.sv
// Data hazard forwarding unit
`timescale 1ns/100ps

module ForwardingUnit import cpuPkg::*; (
  input  logic [RegIdW-1:0] idExSrc1,      // First source of the instruction in EX
  input  logic [RegIdW-1:0] idExSrc2,      // Second source of the instruction in EX
  input  logic [RegIdW-1:0] exMemSrc2,     // Store data register of the instruction in MEM
  input  logic [RegIdW-1:0] exMemDst,      // Destination of the instruction in MEM
  input  logic [RegIdW-1:0] memWbDst,      // Destination of the instruction in WB
  input  logic              exMemRegWrite, // Cleared by the caller when EX/MEM holds a bubble
  input  logic              memWbRegWrite, // Cleared by the caller when MEM/WB holds a bubble
  output fwdSelE            forwardA,      // Operand A select for the EX stage
  output fwdSelE            forwardB,      // Operand B select for the EX stage
  output logic              forwardMem     // Store data comes from the write-back value
);

  logic exMemLive;   // EX/MEM will write a real register
  logic memWbLive;   // MEM/WB will write a real register
  logic exToExHazA;  // Operand A needs the ALU result one stage ahead
  logic exToExHazB;  // Operand B needs the ALU result one stage ahead
  logic memToExHazA; // Operand A needs the write-back value
  logic memToExHazB; // Operand B needs the write-back value

  // Register 0 always reads zero so it never takes part in forwarding
  assign exMemLive = exMemRegWrite & (exMemDst != '0);
  assign memWbLive = memWbRegWrite & (memWbDst != '0);

  ////////////////////
  // EX to EX hazards
  ////////////////////
  assign exToExHazA = exMemLive & (exMemDst == idExSrc1);
  assign exToExHazB = exMemLive & (exMemDst == idExSrc2);

  ////////////////////
  // MEM to EX hazards
  ////////////////////
  // The younger producer in EX/MEM shadows an older one in MEM/WB
  assign memToExHazA = memWbLive & ~exToExHazA & (memWbDst == idExSrc1);
  assign memToExHazB = memWbLive & ~exToExHazB & (memWbDst == idExSrc2);

  always_comb begin
    forwardA = FWD_NONE;
    if (exToExHazA) begin
      forwardA = FWD_EXMEM;
    end else if (memToExHazA) begin
      forwardA = FWD_MEMWB;
    end
  end

  always_comb begin
    forwardB = FWD_NONE;
    if (exToExHazB) begin
      forwardB = FWD_EXMEM;
    end else if (memToExHazB) begin
      forwardB = FWD_MEMWB;
    end
  end

  ////////////////////
  // MEM to MEM hazard
  ////////////////////
  // Covers a load followed directly by a store of the loaded register
  assign forwardMem = memWbLive & (memWbDst == exMemSrc2);

endmodule

// File: design/ExecuteStage.sv
// Execute stage with ALU
`timescale 1ns/100ps

module ExecuteStage import cpuPkg::*; (
  input  logic              clk,
  input  logic              rstN,
  // ID/EX fields
  input  logic              idExValid,
  input  aluOpE             idExOp,
  input  logic [RegIdW-1:0] idExSrc2,
  input  logic [RegIdW-1:0] idExDst,
  input  logic              idExRegWrite,
  input  logic [ImmW-1:0]   idExImm,
  input  logic [DataW-1:0]  idExData1,
  input  logic [DataW-1:0]  idExData2,
  // Forwarding
  input  fwdSelE            forwardA,
  input  fwdSelE            forwardB,
  input  logic [DataW-1:0]  memWbData,    // Value held in MEM/WB
  // EX/MEM pipeline register
  output logic              exMemValid,
  output aluOpE             exMemOp,
  output logic [RegIdW-1:0] exMemDst,
  output logic              exMemRegWrite,
  output logic [RegIdW-1:0] exMemSrc2,
  output logic [DataW-1:0]  exMemResult,  // Also read back here for EX to EX forwarding
  output logic [DataW-1:0]  exMemStoreData
);

  logic [DataW-1:0] opA;        // Operand A after forwarding
  logic [DataW-1:0] opB;        // Operand B after forwarding
  logic [DataW-1:0] aluResult;  // Result headed for EX/MEM
  logic             usesA;      // Opcode consumes operand A in this stage
  logic             usesB;      // Opcode consumes operand B in this stage

  ////////////////////
  // Operand muxes
  ////////////////////
  always_comb begin
    case (forwardA)
      FWD_EXMEM: opA = exMemResult;
      FWD_MEMWB: opA = memWbData;
      default:   opA = idExData1;
    endcase
  end

  always_comb begin
    case (forwardB)
      FWD_EXMEM: opB = exMemResult;
      FWD_MEMWB: opB = memWbData;
      default:   opB = idExData2;
    endcase
  end

  ////////////////////
  // ALU
  ////////////////////
  // Loads and stores pass operand A through as the memory address
  always_comb begin
    case (idExOp)
      OP_ADD:  aluResult = opA + opB;
      OP_SUB:  aluResult = opA - opB;
      OP_AND:  aluResult = opA & opB;
      OP_XOR:  aluResult = opA ^ opB;
      OP_SLL:  aluResult = opA << opB[ShamtW-1:0];
      OP_LLI:  aluResult = {{(DataW-ImmW){1'b0}}, idExImm};
      default: aluResult = opA;  // OP_LW and OP_SW
    endcase
  end

  ////////////////////
  // EX/MEM register
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      exMemValid    <= 1'b0;
      exMemRegWrite <= 1'b0;
      exMemOp       <= OP_ADD;
      exMemDst      <= '0;
      exMemSrc2     <= '0;
    end else begin
      exMemValid    <= idExValid;
      exMemRegWrite <= idExRegWrite;
      exMemOp       <= idExOp;
      exMemDst      <= idExDst;
      exMemSrc2     <= idExSrc2;  // Lets the MEM stage repair store data from a load
    end
  end

  always_ff @(posedge clk) begin
    exMemResult    <= aluResult;
    exMemStoreData <= opB;  // Store data as best known at EX time
  end

  // LLI reads no register and a store's data operand is settled later in MEM
  assign usesA = (idExOp != OP_LLI);
  assign usesB = (idExOp != OP_LLI) && (idExOp != OP_LW) && (idExOp != OP_SW);

  // A load result only exists after MEM so an EX consumer directly behind it would
  // pick up the load address instead
  loadUseA: assert property (@(posedge clk) disable iff (!rstN)
    !(idExValid && usesA && (forwardA == FWD_EXMEM) && (exMemOp == OP_LW)))
    else $error("Load result used by operand A in the next slot");

  loadUseB: assert property (@(posedge clk) disable iff (!rstN)
    !(idExValid && usesB && (forwardB == FWD_EXMEM) && (exMemOp == OP_LW)))
    else $error("Load result used by operand B in the next slot");

endmodule

// File: design/MemoryStage.sv
// Memory stage and write-back register
`timescale 1ns/100ps

module MemoryStage import cpuPkg::*; (
  input  logic              clk,
  input  logic              rstN,
  // EX/MEM fields
  input  logic              exMemValid,
  input  aluOpE             exMemOp,
  input  logic [RegIdW-1:0] exMemDst,
  input  logic              exMemRegWrite,
  input  logic [DataW-1:0]  exMemResult,
  input  logic [DataW-1:0]  exMemStoreData,
  input  logic              forwardMem,   // Store data register is being written back
  // MEM/WB register and top level write-back
  output logic              wbValid,
  output logic [RegIdW-1:0] wbReg,
  output logic [DataW-1:0]  wbData,
  output logic              wbWrite
);

  logic [DataW-1:0]    dataMem [MemWords];  // Sixteen words of data memory
  logic [MemAddrW-1:0] memAddr;             // Word address from the low bits of operand A
  logic                storeEn;             // A valid store sits in EX/MEM
  logic [DataW-1:0]    storeVal;            // Store data after MEM to MEM forwarding
  logic [DataW-1:0]    stageResult;         // Value headed for MEM/WB

  assign memAddr = exMemResult[MemAddrW-1:0];
  assign storeEn = exMemValid & (exMemOp == OP_SW);

  // The write-back value is newer than what EX captured when a load sat right before
  assign storeVal = forwardMem ? wbData : exMemStoreData;

  ////////////////////
  // Data memory
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 0; i < MemWords; i++) begin
        dataMem[i] <= '0;
      end
    end else if (storeEn) begin
      dataMem[memAddr] <= storeVal;  // Store commits at the same edge as MEM/WB
    end
  end

  // Loads read asynchronously so a store one slot earlier is already visible
  assign stageResult = (exMemOp == OP_LW) ? dataMem[memAddr] : exMemResult;

  ////////////////////
  // MEM/WB register
  ////////////////////
  always_ff @(posedge clk) begin
    if (!rstN) begin
      wbValid <= 1'b0;
      wbWrite <= 1'b0;
      wbReg   <= '0;
    end else begin
      wbValid <= exMemValid;     // High for exactly one cycle per instruction
      wbWrite <= exMemRegWrite;  // Set for register 0 too and the file ignores it
      wbReg   <= exMemDst;
    end
  end

  always_ff @(posedge clk) begin
    wbData <= stageResult;
  end

  // Forwarded store data has to come from a real instruction sitting in MEM/WB
  storeFwdLive: assert property (@(posedge clk) disable iff (!rstN)
    (storeEn && forwardMem) |-> wbValid)
    else $error("Store took its data from an empty write-back slot");

endmodule

// File: design/ExecutePipe.sv
// Execute pipe top level
`timescale 1ns/100ps

module ExecutePipe import cpuPkg::*; (
  input  logic              clk,
  input  logic              rstN,
  // One instruction per cycle as loose fields
  input  logic              issueValid,
  input  aluOpE             issueOp,
  input  logic [RegIdW-1:0] issueSrc1,
  input  logic [RegIdW-1:0] issueSrc2,
  input  logic [RegIdW-1:0] issueDst,
  input  logic [ImmW-1:0]   issueImm,
  // Write-back three register stages after issue
  output logic              wbValid,
  output logic [RegIdW-1:0] wbReg,
  output logic [DataW-1:0]  wbData,
  output logic              wbWrite
);

  ////////////////////
  // Stage wiring
  ////////////////////
  logic              idExValid;
  aluOpE             idExOp;
  logic [RegIdW-1:0] idExSrc1;
  logic [RegIdW-1:0] idExSrc2;
  logic [RegIdW-1:0] idExDst;
  logic              idExRegWrite;
  logic [ImmW-1:0]   idExImm;
  logic [DataW-1:0]  idExData1;
  logic [DataW-1:0]  idExData2;
  fwdSelE            forwardA;
  fwdSelE            forwardB;
  logic              forwardMem;
  logic              exMemValid;
  aluOpE             exMemOp;
  logic [RegIdW-1:0] exMemDst;
  logic              exMemRegWrite;
  logic [RegIdW-1:0] exMemSrc2;
  logic [DataW-1:0]  exMemResult;
  logic [DataW-1:0]  exMemStoreData;

  // Register read and write-back
  OperandFetch uFetch (
    .clk, .rstN,
    .issueValid, .issueOp, .issueSrc1, .issueSrc2, .issueDst, .issueImm,
    .wbValid, .wbWrite, .wbReg, .wbData,
    .idExValid, .idExOp, .idExSrc1, .idExSrc2, .idExDst, .idExRegWrite,
    .idExImm, .idExData1, .idExData2
  );

  // MEM/WB destination and write enable double as the write-back outputs
  ForwardingUnit uFwd (
    .idExSrc1, .idExSrc2, .exMemSrc2, .exMemDst,
    .memWbDst(wbReg),
    .exMemRegWrite,
    .memWbRegWrite(wbWrite),
    .forwardA, .forwardB, .forwardMem
  );

  ExecuteStage uExec (
    .clk, .rstN,
    .idExValid, .idExOp, .idExSrc2, .idExDst, .idExRegWrite,
    .idExImm, .idExData1, .idExData2,
    .forwardA, .forwardB,
    .memWbData(wbData),
    .exMemValid, .exMemOp, .exMemDst, .exMemRegWrite, .exMemSrc2,
    .exMemResult, .exMemStoreData
  );

  MemoryStage uMem (
    .clk, .rstN,
    .exMemValid, .exMemOp, .exMemDst, .exMemRegWrite,
    .exMemResult, .exMemStoreData, .forwardMem,
    .wbValid, .wbReg, .wbData, .wbWrite
  );

endmodule

// File: test/ClockGen.sv
// Testbench clock and reset
`timescale 1ns/100ps

module ClockGen (
  output logic clk,
  output logic rstN
);

  localparam real HalfPeriod = 2.0;  // 4 ns clock period
  localparam int  ResetCycles = 10;  // Reset held low for this many rising edges

  initial begin
    clk  = 1'b0;
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge clk);
    #1 rstN = 1'b1;  // Released just after an edge like every other input
  end

  always #(HalfPeriod) clk = ~clk;

endmodule

// File: test/ExecutePipeTb.sv
// Execute pipe testbench
`timescale 1ns/100ps

module ExecutePipeTb import cpuPkg::*; ();

  ////////////////////
  // Run length
  ////////////////////
  // Slot budgets per test plus drain time, reset and margin
  localparam int TotalCycles = 10 + 32 + 178 + 120 + 120 + 30 + 120 + 6 * 4 + 20;

  logic              clk;
  logic              rstN;
  logic              issueValid;
  aluOpE             issueOp;
  logic [RegIdW-1:0] issueSrc1;
  logic [RegIdW-1:0] issueSrc2;
  logic [RegIdW-1:0] issueDst;
  logic [ImmW-1:0]   issueImm;
  logic              wbValid;
  logic [RegIdW-1:0] wbReg;
  logic [DataW-1:0]  wbData;
  logic              wbWrite;

  integer           seed = 32'h749a843f;  // Fixed seed so every run sees the same program
  int               errorCount = 0;        // All errors of the run
  int               testsPassed = 0;
  int               testsFailed = 0;
  int               cycleCnt = 0;          // Rising edges seen so far
  string            curTest = "reset";
  logic [DataW-1:0] modelReg [NumRegs];    // Architectural registers as the model sees them
  logic [DataW-1:0] modelMem [MemWords];   // Data memory as the model sees it
  logic [RegIdW-1:0] expReg [$];           // Expected write-backs in program order
  logic [DataW-1:0]  expData [$];
  logic              expWrite [$];
  int                expCycle [$];         // Cycle on which each instruction was driven

  ClockGen uClk (.clk, .rstN);

  ExecutePipe DUT (
    .clk, .rstN,
    .issueValid, .issueOp, .issueSrc1, .issueSrc2, .issueDst, .issueImm,
    .wbValid, .wbReg, .wbData, .wbWrite
  );

  always @(posedge clk) cycleCnt <= cycleCnt + 1;

  // Compares one value and reports a mismatch
  task automatic checkValue(input string what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s %s expected %0h actual %0h", curTest, what, expected, actual);
      errorCount++;
    end
  endtask

  function automatic int pick(input int n);
    pick = $unsigned($random(seed)) % n;
  endfunction

  ////////////////////
  // Issue and model
  ////////////////////
  // Runs the instruction on the model in program order then drives it for one slot
  task automatic issue(input aluOpE op, input int s1, input int s2, input int dst,
                       input int imm);
    logic [DataW-1:0] a;
    logic [DataW-1:0] b;
    logic [DataW-1:0] res;
    a = modelReg[s1];
    b = modelReg[s2];
    case (op)
      OP_ADD:  res = a + b;
      OP_SUB:  res = a - b;
      OP_AND:  res = a & b;
      OP_XOR:  res = a ^ b;
      OP_SLL:  res = a << b[3:0];
      OP_LLI:  res = DataW'(imm % 256);
      OP_LW:   res = modelMem[a[MemAddrW-1:0]];
      default: begin
        res = a;  // A store reports its address on the write-back bus
        modelMem[a[MemAddrW-1:0]] = b;
      end
    endcase
    if (op != OP_SW && dst != 0) modelReg[dst] = res;  // Register 0 stays zero
    expReg.push_back(dst[RegIdW-1:0]);
    expData.push_back(res);
    expWrite.push_back(op != OP_SW);
    expCycle.push_back(cycleCnt);
    issueValid = 1'b1;
    issueOp    = op;
    issueSrc1  = s1[RegIdW-1:0];
    issueSrc2  = s2[RegIdW-1:0];
    issueDst   = dst[RegIdW-1:0];
    issueImm   = imm[ImmW-1:0];
    @(posedge clk);
    #1;
  endtask

  task automatic bubble(input int n);
    issueValid = 1'b0;
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  // Waits until every queued write-back has come out, the watchdog bounds this
  task automatic finishTest(input int errorsBefore);
    bubble(1);
    while (expReg.size() != 0) bubble(1);
    bubble(1);
    if (errorCount == errorsBefore) begin
      $display("Test %s passed", curTest);
      testsPassed++;
    end else begin
      $display("Test %s failed with %0d errors", curTest, errorCount - errorsBefore);
      testsFailed++;
    end
  endtask

  function automatic aluOpE randomAlu();
    randomAlu = aluOpE'(pick(5));  // ADD through SLL
  endfunction

  ////////////////////
  // Write-back monitor
  ////////////////////
  // Sampled on the falling edge where the MEM/WB outputs are settled
  always @(negedge clk) begin
    if (wbValid === 1'b1) begin
      if (expReg.size() == 0) begin
        $display("Error in %s: write-back seen with nothing outstanding", curTest);
        errorCount++;
      end else begin
        checkValue("wbReg", 32'(expReg.pop_front()), 32'(wbReg));
        checkValue("wbData", 32'(expData.pop_front()), 32'(wbData));
        checkValue("wbWrite", 32'(expWrite.pop_front()), 32'(wbWrite));
        checkValue("latency", 3, cycleCnt - expCycle.pop_front());
      end
    end
  end

  // Watchdog
  initial begin
    #(TotalCycles * 4);
    $display("Error: pipeline stalled, %0d write-backs never arrived", expReg.size());
    $display("SIMULATION FAILED");
    $finish;
  end

  ////////////////////
  // Tests
  ////////////////////
  initial begin
    int e;
    int d;
    int s;
    int ld;
    issueValid = 1'b0;
    issueOp    = OP_ADD;
    issueSrc1  = '0;
    issueSrc2  = '0;
    issueDst   = '0;
    issueImm   = '0;
    for (int i = 0; i < NumRegs; i++) modelReg[i] = '0;
    for (int i = 0; i < MemWords; i++) modelMem[i] = '0;
    @(posedge rstN);
    bubble(1);  // Monitor flags any write-back in this first cycle

    curTest = "resetQuiet";
    e = errorCount;
    for (int i = 0; i < 8; i++) begin
      issue(OP_LLI, 0, 0, 1 + pick(15), pick(256));
      bubble(3);
    end
    finishTest(e);

    curTest = "randomIndependent";
    e = errorCount;
    for (int r = 1; r < NumRegs; r++) issue(OP_LLI, 0, 0, r, pick(256));
    bubble(3);
    for (int i = 0; i < 40; i++) begin
      issue(randomAlu(), pick(16), pick(16), 1 + pick(15), pick(256));
      bubble(3);  // Far enough apart that only the register file supplies operands
    end
    finishTest(e);

    curTest = "backToBack";
    e = errorCount;
    for (int i = 0; i < 60; i++) begin
      // Few registers so EX/MEM and MEM/WB often hold the same destination
      issue(pick(6) == 0 ? OP_LLI : randomAlu(), pick(4), pick(4), 1 + pick(3), pick(256));
      if (pick(2) == 1) bubble(1);
    end
    finishTest(e);

    curTest = "writeThrough";
    e = errorCount;
    for (int i = 0; i < 20; i++) begin
      d = 1 + pick(15);
      issue(OP_LLI, 0, 0, d, pick(256));
      bubble(2);  // Consumer reads while the producer is in write-back
      issue(randomAlu(), d, pick(2) ? d : pick(16), 1 + pick(15), 0);
      bubble(2);
    end
    finishTest(e);

    curTest = "registerZero";
    e = errorCount;
    for (int i = 0; i < 10; i++) begin
      issue(randomAlu(), 1 + pick(15), 1 + pick(15), 0, 0);
      issue(OP_ADD, 0, pick(2) ? 0 : pick(16), 1 + pick(15), 0);  // Register 0 must read zero
      bubble(1);
    end
    finishTest(e);

    curTest = "loadStore";
    e = errorCount;
    ld = 0;  // Destination of a load in the previous slot, zero when there is none
    for (int i = 0; i < 50; i++) begin
      s = pick(16);
      d = 1 + pick(15);
      case (pick(5))
        0: begin
          if (ld != 0) bubble(1);  // No ALU consumer directly behind a load
          issue(randomAlu(), s, pick(16), d, 0);
          ld = 0;
        end
        1: begin
          if (s == ld && ld != 0) bubble(1);
          issue(OP_LW, s, 0, d, 0);
          ld = d;
        end
        2: begin
          if (s == ld && ld != 0) bubble(1);
          issue(OP_SW, s, pick(16), 0, 0);
          ld = 0;
        end
        3: begin
          // Load then store of the loaded register in the next slot
          if (s == ld && ld != 0) bubble(1);
          issue(OP_LW, s, 0, d, 0);
          issue(OP_SW, (d + 1 + pick(14)) % NumRegs, d, 0, 0);
          ld = 0;
        end
        default: begin
          issue(OP_LLI, 0, 0, d, pick(256));
          ld = 0;
        end
      endcase
    end
    bubble(1);
    for (int a = 1; a < NumRegs; a++) issue(OP_LLI, 0, 0, a, a);
    // Every word is read back into register 0 so the address registers stay intact
    for (int a = 0; a < NumRegs; a++) issue(OP_LW, a, 0, 0, 0);
    finishTest(e);

    $display("Tests passed %0d failed %0d", testsPassed, testsFailed);
    if (errorCount == 0 && testsFailed == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: files.f
design/cpuPkg.sv
design/OperandFetch.sv
design/ForwardingUnit.sv
design/ExecuteStage.sv
design/MemoryStage.sv
design/ExecutePipe.sv
test/ClockGen.sv
test/ExecutePipeTb.sv

// File: run.sh
#!/bin/sh
# Build and run the execute pipe testbench with Verilator
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert --top-module ExecutePipeTb -f files.f -o simv \
  && ./obj_dir/simv > sim.log 2>&1 \
  ; cat sim.log 2>/dev/null \
  ; grep -qx "SIMULATION PASSED" sim.log \
  && echo "Run passed" \
  || { echo "Run failed"; exit 1; }
